/* hw/jtag_dma_pkg.sv */
package jtag_dma_pkg;

    // chain geometry
    localparam int CHAIN_W    = 36;
    localparam int OPCODE_W   = 4;
    // payload doubles as dma address and buffer data width
    localparam int PAYLOAD_W  = 32;

    // dma configuration fields
    localparam int BE_W       = 4;
    localparam int BURST_W    = 8;

    // ping-pong buffer side
    localparam int BUF_ADDR_W = 9;

    // 3-bit state plus write, read and switch flags
    localparam int STATUS_W   = 6;

    // opcodes carried in the low nibble of the chain
    typedef enum logic [OPCODE_W-1:0] {
        OP_SET_ADDR     = 4'b0001,
        OP_SET_BE       = 4'b0010,
        OP_SET_BURST    = 4'b0011,
        OP_SHOW_ADDR    = 4'b0100,
        OP_SHOW_BE      = 4'b0101,
        OP_SHOW_BURST   = 4'b0110,
        OP_PUSH_WORD    = 4'b1000,
        OP_LAUNCH_WRITE = 4'b1010,
        OP_LAUNCH_READ  = 4'b1011,
        OP_SWITCH_ONLY  = 4'b1100,
        OP_CLEAR        = 4'b1111
    } opcode_e;

    // update register layout, opcode sits in bits 3:0
    // since it is shifted in first
    typedef struct packed {
        logic [PAYLOAD_W-1:0] payload;
        opcode_e              opcode;
    } chain_cmd_t;

    // settings presented to the dma engine
    typedef struct packed {
        logic [PAYLOAD_W-1:0] addr;
        logic [BE_W-1:0]      be;
        logic [BURST_W-1:0]   burst;
    } dma_cfg_t;

    // which launch the sequencer is running
    typedef enum logic [1:0] {
        LK_NONE   = 2'd0,
        LK_WRITE  = 2'd1,
        LK_READ   = 2'd2,
        LK_SWITCH = 2'd3
    } launch_kind_e;

    // launch sequencer states, also decoded from the status word
    typedef enum logic [2:0] {
        IDLE            = 3'd0,
        WAIT_FOR_DMA    = 3'd1,
        SWITCH_BUFFER   = 3'd2,
        LAUNCH_DMA      = 3'd3,
        END_INSTRUCTION = 3'd4
    } seq_state_e;

endpackage

/* hw/jtag_shift_chain.sv */
`timescale 1ns/1ps

module jtag_shift_chain (
    input  logic                                JTCK,
    input  logic                                n_reset,
    input  logic                                jtdi,
    input  logic                                jshift,
    input  logic                                jupdate,
    input  logic                                jce,
    input  logic [jtag_dma_pkg::CHAIN_W-1:0]    capture_word,
    output logic                                jtdo,
    output jtag_dma_pkg::chain_cmd_t            cmd,
    output logic                                cmd_valid
);
    import jtag_dma_pkg::*;

    logic [CHAIN_W-1:0] shift_q;

    // shift and capture share the one chain register
    always_ff @(posedge JTCK) begin
        if (!n_reset) begin
            shift_q <= '0;
        end else if (jce) begin
            if (jshift) begin
                // new bit enters at the top, lsb leaves on jtdo
                shift_q <= {jtdi, shift_q[CHAIN_W-1:1]};
            end else begin
                // capture phase
                shift_q <= capture_word;
            end
        end
    end

    // bit 0 is always the next bit out
    assign jtdo = shift_q[0];

    // update register, loaded from the chain on jupdate
    always_ff @(posedge JTCK) begin
        if (jupdate) begin
            cmd <= chain_cmd_t'(shift_q);
        end
    end

    // one cycle behind jupdate so cmd is already stable
    always_ff @(posedge JTCK) begin
        if (!n_reset) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= jupdate;
        end
    end

endmodule

/* hw/chain_cfg_regs.sv */
`timescale 1ns/1ps

module chain_cfg_regs (
    input  logic                                JTCK,
    input  logic                                n_reset,
    input  jtag_dma_pkg::chain_cmd_t            cmd,
    input  logic                                cmd_valid,
    input  logic [jtag_dma_pkg::STATUS_W-1:0]   status,
    output jtag_dma_pkg::dma_cfg_t              cfg,
    output logic                                be_nonzero,
    output logic [jtag_dma_pkg::CHAIN_W-1:0]    capture_word,
    output logic                                soft_clear
);
    import jtag_dma_pkg::*;

    // last accepted opcode, steers the capture mux
    opcode_e show_sel_q;

    // clear is decoded straight off the command so every block
    // resets on the same edge
    assign soft_clear = cmd_valid && (cmd.opcode == OP_CLEAR);

    always_ff @(posedge JTCK) begin
        if (!n_reset || soft_clear) begin
            cfg.addr  <= '0;
            // all lanes enabled by default
            cfg.be    <= '1;
            cfg.burst <= '0;
        end else if (cmd_valid) begin
            case (cmd.opcode)
                OP_SET_ADDR: begin
                    cfg.addr <= cmd.payload;
                end
                OP_SET_BE: begin
                    // only the low bits of the payload count
                    cfg.be <= cmd.payload[BE_W-1:0];
                end
                OP_SET_BURST: begin
                    cfg.burst <= cmd.payload[BURST_W-1:0];
                end
                default: begin
                    // other opcodes leave the config alone
                    cfg <= cfg;
                end
            endcase
        end
    end

    // readback select follows every command
    always_ff @(posedge JTCK) begin
        if (!n_reset) begin
            // any non-show opcode selects status
            show_sel_q <= OP_CLEAR;
        end else if (cmd_valid) begin
            show_sel_q <= cmd.opcode;
        end
    end

    // launch needs at least one lane
    assign be_nonzero = |cfg.be;

    // capture word, values zero-extended into the low chain bits
    always_comb begin
        case (show_sel_q)
            OP_SHOW_ADDR:  capture_word = CHAIN_W'(cfg.addr);
            OP_SHOW_BE:    capture_word = CHAIN_W'(cfg.be);
            OP_SHOW_BURST: capture_word = CHAIN_W'(cfg.burst);
            // status is live, not a snapshot
            default:       capture_word = CHAIN_W'(status);
        endcase
    end

endmodule

/* hw/buffer_fill.sv */
`timescale 1ns/1ps

module buffer_fill #(
    parameter int count_w = 8
) (
    input  logic                                    JTCK,
    input  logic                                    n_reset,
    input  logic                                    soft_clear,
    input  jtag_dma_pkg::chain_cmd_t                cmd,
    input  logic                                    cmd_valid,
    input  logic                                    buf_switch,
    input  logic [count_w-1:0]                      dma_block_size,
    output logic [count_w-1:0]                      word_count,
    output logic [jtag_dma_pkg::BUF_ADDR_W-1:0]     pp_address,
    output logic                                    pp_write_enable,
    output logic [jtag_dma_pkg::PAYLOAD_W-1:0]      pp_data_in
);
    import jtag_dma_pkg::*;

    logic full;
    logic push;

    // counter saturates at all ones
    assign full = (word_count == '1);
    assign push = cmd_valid && (cmd.opcode == OP_PUSH_WORD) && !full;

    // word counter and write strobe
    always_ff @(posedge JTCK) begin
        if (!n_reset || soft_clear) begin
            word_count      <= '0;
            pp_write_enable <= 1'b0;
        end else begin
            // one write cycle per accepted push
            pp_write_enable <= push;
            if (buf_switch) begin
                // other half of the buffer, count comes from the dma
                word_count <= dma_block_size;
            end else if (push) begin
                word_count <= word_count + 1'b1;
            end
        end
    end

    // address and data held for the write cycle
    always_ff @(posedge JTCK) begin
        if (push) begin
            // address is the count before the increment
            pp_address <= BUF_ADDR_W'(word_count);
            pp_data_in <= cmd.payload;
        end
    end

endmodule

/* hw/dma_launch_seq.sv */
`timescale 1ns/1ps

module dma_launch_seq #(
    parameter int count_w = 8
) (
    input  logic                                JTCK,
    input  logic                                n_reset,
    input  logic                                soft_clear,
    input  jtag_dma_pkg::chain_cmd_t            cmd,
    input  logic                                cmd_valid,
    input  logic [count_w-1:0]                  word_count,
    input  logic                                be_nonzero,
    input  logic                                dma_busy,
    output logic                                buf_switch,
    output logic                                dma_launch_write,
    output logic                                dma_launch_read,
    output logic [jtag_dma_pkg::STATUS_W-1:0]   status
);
    import jtag_dma_pkg::*;

    seq_state_e   state_q;
    seq_state_e   state_d;
    launch_kind_e kind_q;
    launch_kind_e cmd_kind;
    logic         launch_ok;

    // which launch the incoming opcode asks for
    always_comb begin
        case (cmd.opcode)
            OP_LAUNCH_WRITE: cmd_kind = LK_WRITE;
            OP_LAUNCH_READ:  cmd_kind = LK_READ;
            OP_SWITCH_ONLY:  cmd_kind = LK_SWITCH;
            default:         cmd_kind = LK_NONE;
        endcase
    end

    // switch-only skips the data checks
    assign launch_ok = cmd_valid && (cmd_kind != LK_NONE) &&
                       (((word_count != '0) && be_nonzero) || (cmd_kind == LK_SWITCH));

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (launch_ok) begin
                    state_d = WAIT_FOR_DMA;
                end
            end
            WAIT_FOR_DMA: begin
                // hold here as long as the dma is busy
                if (!dma_busy) begin
                    state_d = SWITCH_BUFFER;
                end
            end
            SWITCH_BUFFER:   state_d = LAUNCH_DMA;
            LAUNCH_DMA:      state_d = END_INSTRUCTION;
            END_INSTRUCTION: state_d = IDLE;
            default:         state_d = IDLE;
        endcase
    end

    // launches outside IDLE are simply dropped
    always_ff @(posedge JTCK) begin
        if (!n_reset || soft_clear) begin
            state_q <= IDLE;
            kind_q  <= LK_NONE;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE && launch_ok) begin
                kind_q <= cmd_kind;
            end else if (state_q == END_INSTRUCTION) begin
                kind_q <= LK_NONE;
            end
        end
    end

    // buffer swap, then the matching launch a cycle later
    assign buf_switch       = (state_q == SWITCH_BUFFER);
    assign dma_launch_write = (state_q == LAUNCH_DMA) && (kind_q == LK_WRITE);
    assign dma_launch_read  = (state_q == LAUNCH_DMA) && (kind_q == LK_READ);

    // state in the top three bits
    assign status = {state_q, dma_launch_write, dma_launch_read, buf_switch};

endmodule

/* hw/chain1_top.sv */
`timescale 1ns/1ps

module chain1_top #(
    parameter int count_w = 8
) (
    input  logic                                    JTCK,
    input  logic                                    n_reset,
    // jtag user chain
    input  logic                                    jtdi,
    input  logic                                    jshift,
    input  logic                                    jupdate,
    input  logic                                    jce,
    output logic                                    jtdo,
    // ping-pong buffer
    output logic [jtag_dma_pkg::BUF_ADDR_W-1:0]     pp_address,
    output logic                                    pp_write_enable,
    output logic [jtag_dma_pkg::PAYLOAD_W-1:0]      pp_data_in,
    output logic                                    pp_switch,
    // dma engine
    output jtag_dma_pkg::dma_cfg_t                  dma_cfg,
    output logic                                    dma_launch_write,
    output logic                                    dma_launch_read,
    input  logic                                    dma_busy,
    input  logic [count_w-1:0]                      dma_block_size,
    // debug leds
    output logic [jtag_dma_pkg::STATUS_W-1:0]       status_out
);
    import jtag_dma_pkg::*;

    chain_cmd_t         cmd;
    logic               cmd_valid;
    logic [CHAIN_W-1:0] capture_word;
    logic               be_nonzero;
    logic               soft_clear;
    logic [count_w-1:0] word_count;

    // shift register and update strobe
    jtag_shift_chain u_chain (
        .JTCK         (JTCK),
        .n_reset      (n_reset),
        .jtdi         (jtdi),
        .jshift       (jshift),
        .jupdate      (jupdate),
        .jce          (jce),
        .capture_word (capture_word),
        .jtdo         (jtdo),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid)
    );

    // config registers and readback
    chain_cfg_regs u_regs (
        .JTCK         (JTCK),
        .n_reset      (n_reset),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .status       (status_out),
        .cfg          (dma_cfg),
        .be_nonzero   (be_nonzero),
        .capture_word (capture_word),
        .soft_clear   (soft_clear)
    );

    // buffer write port
    buffer_fill #(
        .count_w (count_w)
    ) u_fill (
        .JTCK            (JTCK),
        .n_reset         (n_reset),
        .soft_clear      (soft_clear),
        .cmd             (cmd),
        .cmd_valid       (cmd_valid),
        .buf_switch      (pp_switch),
        .dma_block_size  (dma_block_size),
        .word_count      (word_count),
        .pp_address      (pp_address),
        .pp_write_enable (pp_write_enable),
        .pp_data_in      (pp_data_in)
    );

    // launch sequencer, also owns the buffer switch
    dma_launch_seq #(
        .count_w (count_w)
    ) u_seq (
        .JTCK             (JTCK),
        .n_reset          (n_reset),
        .soft_clear       (soft_clear),
        .cmd              (cmd),
        .cmd_valid        (cmd_valid),
        .word_count       (word_count),
        .be_nonzero       (be_nonzero),
        .dma_busy         (dma_busy),
        .buf_switch       (pp_switch),
        .dma_launch_write (dma_launch_write),
        .dma_launch_read  (dma_launch_read),
        .status           (status_out)
    );

endmodule

/* verification/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 10,
    parameter int reset_cycles = 3
) (
    output logic JTCK,
    output logic n_reset
);
    // free running 20 ns clock
    initial begin
        JTCK = 1'b0;
        forever #(half_period) JTCK = ~JTCK;
    end

    // synchronous reset, released on a rising edge
    initial begin
        n_reset = 1'b0;
        repeat (reset_cycles) @(posedge JTCK);
        n_reset <= 1'b1;
    end

endmodule

/* verification/chain1_sva.sv */
`timescale 1ns/1ps

module chain1_sva (
    input logic                              JTCK,
    input logic                              n_reset,
    input jtag_dma_pkg::chain_cmd_t          cmd,
    input logic                              cmd_valid,
    input logic                              pp_write_enable,
    input logic                              pp_switch,
    input logic                              dma_launch_write,
    input logic                              dma_launch_read,
    input logic [jtag_dma_pkg::STATUS_W-1:0] status_out
);
    import jtag_dma_pkg::*;

    // failed assertions so far
    int unsigned fail_count = 0;
    logic [2:0]  state;
    // launch opcode last seen while idle, the one that runs
    opcode_e     launch_op;

    // sequencer state sits in the top three status bits
    assign state = status_out[STATUS_W-1:STATUS_W-3];

    always_ff @(posedge JTCK) begin
        if (!n_reset) begin
            launch_op <= OP_CLEAR;
        end else if (cmd_valid && (state == IDLE) &&
                     (cmd.opcode inside {OP_LAUNCH_WRITE, OP_LAUNCH_READ,
                                         OP_SWITCH_ONLY})) begin
            launch_op <= cmd.opcode;
        end
    end

    // everything quiet and idle as reset lets go
    reset_quiet: assert property (@(posedge JTCK) $rose(n_reset) |->
        !pp_write_enable && !pp_switch && !dma_launch_write && !dma_launch_read &&
        (state == IDLE))
        else begin
            $error("outputs not idle after reset");
            fail_count++;
        end

    switch_single: assert property (@(posedge JTCK) disable iff (!n_reset)
        pp_switch |=> !pp_switch)
        else begin
            $error("pp_switch longer than one cycle");
            fail_count++;
        end

    // switch-only ends quietly, write and read fire their own launch
    switch_then_launch: assert property (@(posedge JTCK) disable iff (!n_reset)
        pp_switch |=> ((launch_op == OP_SWITCH_ONLY) ?
                       (!dma_launch_write && !dma_launch_read) :
                       ((dma_launch_write == (launch_op == OP_LAUNCH_WRITE)) &&
                        (dma_launch_read == (launch_op == OP_LAUNCH_READ)))))
        else begin
            $error("pp_switch not followed by the matching launch");
            fail_count++;
        end

    launch_after_switch: assert property (@(posedge JTCK) disable iff (!n_reset)
        (dma_launch_write || dma_launch_read) |-> $past(pp_switch))
        else begin
            $error("launch pulse without a switch just before");
            fail_count++;
        end

    launch_exclusive: assert property (@(posedge JTCK) disable iff (!n_reset)
        !(dma_launch_write && dma_launch_read))
        else begin
            $error("write and read launch at once");
            fail_count++;
        end

endmodule

bind chain1_top chain1_sva sva0 (
    .JTCK             (JTCK),
    .n_reset          (n_reset),
    .cmd              (cmd),
    .cmd_valid        (cmd_valid),
    .pp_write_enable  (pp_write_enable),
    .pp_switch        (pp_switch),
    .dma_launch_write (dma_launch_write),
    .dma_launch_read  (dma_launch_read),
    .status_out       (status_out)
);

/* verification/chain1_tb.sv */
`timescale 1ns/1ps

module chain1_tb;
    import jtag_dma_pkg::*;

    localparam int count_w        = 8;
    localparam int timeout_cycles = 100;

    logic                  JTCK;
    logic                  n_reset;
    logic                  jtdi;
    logic                  jshift;
    logic                  jupdate;
    logic                  jce;
    logic                  jtdo;
    logic                  dma_busy;
    logic [count_w-1:0]    dma_block_size;
    logic [BUF_ADDR_W-1:0] pp_address;
    logic                  pp_write_enable;
    logic [PAYLOAD_W-1:0]  pp_data_in;
    logic                  pp_switch;
    dma_cfg_t              dma_cfg;
    logic                  dma_launch_write;
    logic                  dma_launch_read;
    logic [STATUS_W-1:0]   status_out;

    logic [31:0]           lfsr = 32'h3011e5a6;
    int unsigned           errors = 0;
    int unsigned           tests_run = 0;
    int unsigned           tests_failed = 0;
    int unsigned           errors_before = 0;
    // filled in by the monitor on falling edges
    int unsigned           cycle = 0;
    int unsigned           writes_seen = 0;
    int unsigned           switches_seen = 0;
    int unsigned           write_launches = 0;
    int unsigned           read_launches = 0;
    int unsigned           switch_cycle = 0;
    int unsigned           launch_cycle = 0;
    logic [BUF_ADDR_W-1:0] last_addr = '0;
    logic [PAYLOAD_W-1:0]  last_data = '0;
    // expected buffer address of the next push
    int unsigned           pushes_since_switch = 0;
    int unsigned           sw0;
    int unsigned           lw0;
    int unsigned           lr0;
    logic [PAYLOAD_W-1:0]  word;
    logic [CHAIN_W-1:0]    cap;

    tb_clock_gen clk0 (
        .JTCK    (JTCK),
        .n_reset (n_reset)
    );

    chain1_top #(
        .count_w (count_w)
    ) dut0 (
        .JTCK             (JTCK),
        .n_reset          (n_reset),
        .jtdi             (jtdi),
        .jshift           (jshift),
        .jupdate          (jupdate),
        .jce              (jce),
        .jtdo             (jtdo),
        .pp_address       (pp_address),
        .pp_write_enable  (pp_write_enable),
        .pp_data_in       (pp_data_in),
        .pp_switch        (pp_switch),
        .dma_cfg          (dma_cfg),
        .dma_launch_write (dma_launch_write),
        .dma_launch_read  (dma_launch_read),
        .dma_busy         (dma_busy),
        .dma_block_size   (dma_block_size),
        .status_out       (status_out)
    );

    // pulse monitor, counters are only read on rising edges
    always @(negedge JTCK) begin
        if (n_reset) begin
            if (pp_write_enable) begin
                writes_seen++;
                last_addr = pp_address;
                last_data = pp_data_in;
            end
            if (pp_switch) begin
                switches_seen++;
                switch_cycle = cycle;
            end
            if (dma_launch_write || dma_launch_read) begin
                launch_cycle = cycle;
            end
            write_launches += dma_launch_write;
            read_launches  += dma_launch_read;
        end
        cycle++;
    end

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per payload bit
    task automatic draw_word(output logic [PAYLOAD_W-1:0] w);
        w = '0;
        for (int i = 0; i < PAYLOAD_W; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[PAYLOAD_W-2:0], lfsr[0]};
        end
    endtask

    function automatic int unsigned total_errors();
        return errors + dut0.sva0.fail_count;
    endfunction

    task automatic check_value(input string name, input logic [CHAIN_W-1:0] got,
                               input logic [CHAIN_W-1:0] exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int unsigned got,
                               input int unsigned exp);
        assert (got == exp) else begin
            $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    // capture, 36 shifts lsb first, then one update cycle
    task automatic shift_cmd(input opcode_e op, input logic [PAYLOAD_W-1:0] payload,
                             output logic [CHAIN_W-1:0] captured);
        logic [CHAIN_W-1:0] chain_word;
        chain_word = {payload, op};
        captured   = '0;
        @(posedge JTCK);
        jce    <= 1'b1;
        jshift <= 1'b0;
        for (int i = 0; i < CHAIN_W; i++) begin
            @(posedge JTCK);
            jshift <= 1'b1;
            jtdi   <= chain_word[i];
            // jtdo holds captured bit i until the next edge
            @(negedge JTCK);
            captured[i] = jtdo;
        end
        @(posedge JTCK);
        jce     <= 1'b0;
        jshift  <= 1'b0;
        jtdi    <= 1'b0;
        jupdate <= 1'b1;
        @(posedge JTCK);
        jupdate <= 1'b0;
        // cmd_valid cycle, then the edge that acts on it
        repeat (2) @(posedge JTCK);
    endtask

    task automatic wait_for_reset();
        int n;
        n = 0;
        do begin
            @(posedge JTCK);
            n++;
        end while (!n_reset && n < timeout_cycles);
        if (!n_reset) begin
            $display("timeout: reset was never released");
            errors++;
        end
    endtask

    // waits until a switch or launch pulse moves its counter past start
    task automatic wait_for_pulse(input bit launch, input int unsigned start);
        int          n;
        int unsigned seen;
        n    = 0;
        seen = start;
        while (seen == start && n < timeout_cycles) begin
            @(posedge JTCK);
            seen = launch ? write_launches + read_launches : switches_seen;
            n++;
        end
        if (seen == start) begin
            $display("timeout: no %s pulse from the DUT", launch ? "launch" : "switch");
            errors++;
        end
    endtask

    // set a field, show it, then read it back on the next capture
    task automatic config_roundtrip(input opcode_e set_op, input opcode_e show_op,
                                    input int width, input string name);
        logic [PAYLOAD_W-1:0] p;
        logic [PAYLOAD_W-1:0] mask;
        logic [PAYLOAD_W-1:0] field;
        logic [CHAIN_W-1:0]   captured;
        mask = '1;
        mask = mask >> (PAYLOAD_W - width);
        draw_word(p);
        shift_cmd(set_op, p, captured);
        @(negedge JTCK);
        case (set_op)
            OP_SET_ADDR: field = dma_cfg.addr;
            OP_SET_BE:   field = PAYLOAD_W'(dma_cfg.be);
            default:     field = PAYLOAD_W'(dma_cfg.burst);
        endcase
        check_value(name, CHAIN_W'(field), CHAIN_W'(p & mask));
        shift_cmd(show_op, '0, captured);
        shift_cmd(show_op, '0, captured);
        check_value({name, " on jtdo"}, captured, CHAIN_W'(p & mask));
    endtask

    task automatic start_test();
        errors_before = total_errors();
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (total_errors() != errors_before) begin
            tests_failed++;
            $display("test %s: failed", name);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    initial begin
        jtdi           = 1'b0;
        jshift         = 1'b0;
        jupdate        = 1'b0;
        jce            = 1'b0;
        dma_busy       = 1'b0;
        dma_block_size = '0;

        start_test();
        wait_for_reset();
        @(negedge JTCK);
        check_value("{pp_write_enable,pp_switch,dma_launch_write,dma_launch_read}",
                    CHAIN_W'({pp_write_enable, pp_switch, dma_launch_write,
                              dma_launch_read}), '0);
        check_value("status_out state", CHAIN_W'(status_out[5:3]), CHAIN_W'(IDLE));
        finish_test("reset state");

        start_test();
        config_roundtrip(OP_SET_ADDR, OP_SHOW_ADDR, PAYLOAD_W, "dma_cfg.addr");
        config_roundtrip(OP_SET_BE, OP_SHOW_BE, BE_W, "dma_cfg.be");
        config_roundtrip(OP_SET_BURST, OP_SHOW_BURST, BURST_W, "dma_cfg.burst");
        // all lanes on so later launches are not refused
        shift_cmd(OP_SET_BE, 32'hf, cap);
        finish_test("config readback");

        start_test();
        for (int i = 0; i < 4; i++) begin
            sw0 = writes_seen;
            draw_word(word);
            shift_cmd(OP_PUSH_WORD, word, cap);
            check_count("pp_write_enable cycles", writes_seen, sw0 + 1);
            check_value("pp_data_in", CHAIN_W'(last_data), CHAIN_W'(word));
            check_count("pp_address", int'(last_addr), pushes_since_switch);
            pushes_since_switch++;
        end
        finish_test("buffer push");

        start_test();
        sw0 = switches_seen;
        lw0 = write_launches;
        dma_busy <= 1'b1;
        shift_cmd(OP_LAUNCH_WRITE, '0, cap);
        repeat (6) @(posedge JTCK);
        check_count("pp_switch while busy", switches_seen, sw0);
        check_count("dma_launch_write while busy", write_launches, lw0);
        @(negedge JTCK);
        check_value("status_out state", CHAIN_W'(status_out[5:3]),
                    CHAIN_W'(WAIT_FOR_DMA));
        @(posedge JTCK);
        dma_busy <= 1'b0;
        wait_for_pulse(1'b1, lw0 + read_launches);
        repeat (3) @(posedge JTCK);
        check_count("pp_switch pulses", switches_seen, sw0 + 1);
        check_count("dma_launch_write pulses", write_launches, lw0 + 1);
        check_count("dma_launch_write cycle", launch_cycle, switch_cycle + 1);
        // counter reloads from the block size on the switch
        pushes_since_switch = dma_block_size;
        finish_test("launch under busy");

        start_test();
        sw0 = switches_seen;
        lr0 = read_launches;
        shift_cmd(OP_LAUNCH_READ, '0, cap);
        repeat (8) @(posedge JTCK);
        check_count("pp_switch on refused read", switches_seen, sw0);
        lw0 = write_launches;
        shift_cmd(OP_SWITCH_ONLY, '0, cap);
        wait_for_pulse(1'b0, sw0);
        repeat (4) @(posedge JTCK);
        check_count("pp_switch on switch-only", switches_seen, sw0 + 1);
        check_count("launch pulses", write_launches + read_launches, lw0 + lr0);
        pushes_since_switch = dma_block_size;
        finish_test("refused and switch-only");

        start_test();
        sw0 = writes_seen;
        draw_word(word);
        shift_cmd(OP_PUSH_WORD, word, cap);
        // first push after the switch
        check_count("pp_write_enable cycles", writes_seen, sw0 + 1);
        check_count("pp_address", int'(last_addr), pushes_since_switch);
        shift_cmd(OP_CLEAR, '0, cap);
        @(negedge JTCK);
        check_value("dma_cfg.addr", CHAIN_W'(dma_cfg.addr), '0);
        check_value("dma_cfg.be", CHAIN_W'(dma_cfg.be), CHAIN_W'(4'hf));
        check_value("dma_cfg.burst", CHAIN_W'(dma_cfg.burst), '0);
        sw0 = switches_seen;
        shift_cmd(OP_LAUNCH_WRITE, '0, cap);
        repeat (8) @(posedge JTCK);
        check_count("pp_switch after clear", switches_seen, sw0);
        finish_test("soft clear");

        $display("%0d tests, %0d failed, %0d check errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut0.sva0.fail_count);
        if (total_errors() == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
hw/jtag_dma_pkg.sv
hw/jtag_shift_chain.sv
hw/chain_cfg_regs.sv
hw/buffer_fill.sv
hw/dma_launch_seq.sv
hw/chain1_top.sv
verification/tb_clock_gen.sv
verification/chain1_sva.sv
verification/chain1_tb.sv

/* Makefile */
SIM      = verilator
TOP      = chain1_tb
FILELIST = sources.f
FLAGS    = --binary --assert --timescale 1ns/1ps -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
